//--- include/decode_issue_cfg.svh
//------------------------------------------------------------
// Configuration macros for the decode and issue stage
// Sequence number width, register count, execute pipe count
//------------------------------------------------------------

`ifndef DECODE_ISSUE_CFG_SVH
`define DECODE_ISSUE_CFG_SVH

// Bounds the number of writes in flight
`define DI_SEQ_NUM_BITS 5

// Architectural registers x0 to x31
`define DI_NUM_REGS 32

// ALU, MUL and MEM
`define DI_NUM_PIPES 3

`endif

//--- hdl/rv_uarch_pkg.sv
//------------------------------------------------------------
// Micro-architecture types for the decode and issue stage
// Uop and pipe enums, instruction format union, decode bundle
//------------------------------------------------------------

`default_nettype none

`include "decode_issue_cfg.svh"

package rv_uarch_pkg;

  typedef logic [`DI_SEQ_NUM_BITS-1:0]    seq_num_t;
  typedef logic [$clog2(`DI_NUM_REGS)-1:0] reg_idx_t;

  // TinyRV1 operations
  typedef enum logic [2:0] {
    OP_ADD,
    OP_ADDI,
    OP_MUL,
    OP_LW,
    OP_SW,
    OP_JAL,
    OP_JALR,
    OP_BNE
  } rv_uop;

  // Value doubles as the pipe index
  typedef enum logic [1:0] {
    PIPE_ALU = 2'd0,
    PIPE_MUL = 2'd1,
    PIPE_MEM = 2'd2
  } pipe_class_e;

  //----------------------------------------------------------
  // Instruction formats
  //----------------------------------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One word, five views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } rv_inst_u;

  // Decoded instruction handed from decoder to router
  typedef struct packed {
    logic [31:0] pc;
    rv_uop       uop;
    pipe_class_e pipe;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        uses_rs1;
    logic        uses_rs2;
    reg_idx_t    waddr;
    logic [31:0] imm;
    logic        op2_is_imm;
  } dec_bundle_t;

endpackage

`default_nettype wire

//--- hdl/decode_issue_ifs.sv
//------------------------------------------------------------
// Internal interfaces of the decode and issue stage
// dec_issue_if joins decoder, router and scoreboard
// complete_if carries completion writes to the scoreboard
//------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

interface dec_issue_if (
  input logic clk
);
  import rv_uarch_pkg::*;

  dec_bundle_t bundle;
  logic        valid;
  logic        accept;

  // Operand read side
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        rs1_busy;
  logic        rs2_busy;

  // Destination claim on accept
  logic        claim;
  reg_idx_t    claim_waddr;
  seq_num_t    claim_seq;

  modport decoder (
    input  clk, accept,
    output bundle, valid
  );

  modport router (
    input  bundle, valid, rs1_data, rs2_data, rs1_busy, rs2_busy,
    output accept, claim, claim_waddr, claim_seq
  );

  modport scoreboard (
    input  bundle, claim, claim_waddr, claim_seq,
    output rs1_data, rs2_data, rs1_busy, rs2_busy
  );

endinterface

interface complete_if;
  import rv_uarch_pkg::*;

  logic        val;
  seq_num_t    seq_num;
  reg_idx_t    waddr;
  logic [31:0] wdata;
  logic        wen;

  modport sink (
    input val, seq_num, waddr, wdata, wen
  );

endinterface

`default_nettype wire

//--- hdl/instr_decoder.sv
//------------------------------------------------------------
// Combinational TinyRV1 decoder
// Uop, register fields, immediate and pipe class per word
//------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  rv_uarch_pkg::rv_inst_u inst,
  input  logic [31:0]            pc,
  input  logic                   f_val,
  dec_issue_if.decoder           dec
);
  import rv_uarch_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  dec_bundle_t b;
  logic        legal;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;

  // Sign-extended immediates, one per format view
  assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
  assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
  assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                  inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
  assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    b            = '0;
    b.pc         = pc;
    b.uop        = OP_ADD;
    b.pipe       = PIPE_ALU;
    b.rs1        = inst.r_fmt.rs1;
    b.rs2        = inst.r_fmt.rs2;
    legal        = 1'b0;

    case (inst.r_fmt.opcode)
      OPC_OP: begin
        b.uses_rs1 = 1'b1;
        b.uses_rs2 = 1'b1;
        b.waddr    = inst.r_fmt.rd;
        if (inst.r_fmt.funct7 == 7'b0000001) begin
          b.uop  = OP_MUL;
          b.pipe = PIPE_MUL;
        end
        legal = (inst.r_fmt.funct3 == 3'b000) &&
                (inst.r_fmt.funct7 == 7'b0000000 || inst.r_fmt.funct7 == 7'b0000001);
      end
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
        // Register plus immediate forms
        b.uses_rs1   = 1'b1;
        b.waddr      = inst.i_fmt.rd;
        b.imm        = imm_i;
        b.op2_is_imm = 1'b1;
        if (inst.i_fmt.opcode == OPC_LOAD) begin
          b.uop  = OP_LW;
          b.pipe = PIPE_MEM;
          legal  = (inst.i_fmt.funct3 == 3'b010);
        end else begin
          b.uop = (inst.i_fmt.opcode == OPC_JALR) ? OP_JALR : OP_ADDI;
          legal = (inst.i_fmt.funct3 == 3'b000);
        end
      end
      OPC_STORE: begin
        b.uop      = OP_SW;
        b.pipe     = PIPE_MEM;
        b.uses_rs1 = 1'b1;
        b.uses_rs2 = 1'b1;
        b.imm      = imm_s;
        legal      = (inst.s_fmt.funct3 == 3'b010);
      end
      OPC_BRANCH: begin
        b.uop      = OP_BNE;
        b.uses_rs1 = 1'b1;
        b.uses_rs2 = 1'b1;
        b.imm      = imm_b;
        legal      = (inst.b_fmt.funct3 == 3'b001);
      end
      OPC_JAL: begin
        // op1 falls back to pc when rs1 is unused
        b.uop   = OP_JAL;
        b.waddr = inst.j_fmt.rd;
        b.imm   = imm_j;
        legal   = 1'b1;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  assign dec.bundle = b;
  assign dec.valid  = f_val;

  // Anything the router takes must be a TinyRV1 word
  a_legal_on_accept: assert property (@(posedge dec.clk) dec.accept |-> legal)
    else $error("instr_decoder: unknown instruction %h at pc %h", inst, pc);

endmodule

`default_nettype wire

//--- hdl/reg_scoreboard.sv
//------------------------------------------------------------
// Register file with scoreboard
// Pending bits, owner sequence numbers, completion forwarding
//------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "decode_issue_cfg.svh"

module reg_scoreboard (
  input  logic            clk,
  input  logic            rst,
  dec_issue_if.scoreboard dec,
  complete_if.sink        comp
);
  import rv_uarch_pkg::*;

  logic [31:0]             regs  [`DI_NUM_REGS];
  seq_num_t                owner [`DI_NUM_REGS];
  logic [`DI_NUM_REGS-1:0] pending;

  logic comp_hit;
  logic rs1_fwd;
  logic rs2_fwd;

  // Only the last writer of a register may retire it
  assign comp_hit = comp.val && comp.wen && (comp.waddr != '0) &&
                    pending[comp.waddr] && (owner[comp.waddr] == comp.seq_num);

  //----------------------------------------------------------
  // Operand read with forwarding
  //----------------------------------------------------------

  assign rs1_fwd = comp_hit && (comp.waddr == dec.bundle.rs1);
  assign rs2_fwd = comp_hit && (comp.waddr == dec.bundle.rs2);

  // x0 is never written or claimed, so it reads 0 and is never busy
  assign dec.rs1_data = rs1_fwd ? comp.wdata : regs[dec.bundle.rs1];
  assign dec.rs2_data = rs2_fwd ? comp.wdata : regs[dec.bundle.rs2];
  assign dec.rs1_busy = pending[dec.bundle.rs1] && !rs1_fwd;
  assign dec.rs2_busy = pending[dec.bundle.rs2] && !rs2_fwd;

  //----------------------------------------------------------
  // Completion write and destination claim
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
      for (int i = 0; i < `DI_NUM_REGS; i++) begin
        regs[i]  <= '0;
        owner[i] <= '0;
      end
    end else begin
      if (comp_hit) begin
        regs[comp.waddr]    <= comp.wdata;
        pending[comp.waddr] <= 1'b0;
      end
      // A claim in the same cycle overrides the clear
      if (dec.claim) begin
        pending[dec.claim_waddr] <= 1'b1;
        owner[dec.claim_waddr]   <= dec.claim_seq;
      end
    end
  end

  // A write-enabled completion always names a real register
  a_comp_waddr_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    (comp.val && comp.wen) |-> (comp.waddr != '0)
  ) else $error("reg_scoreboard: completion write aimed at x0");

endmodule

`default_nettype wire

//--- hdl/issue_router.sv
//------------------------------------------------------------
// Issue router
// Hazard check, sequence numbers, one issue register per pipe
//------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "decode_issue_cfg.svh"

module issue_router (
  input  logic                                           clk,
  input  logic                                           rst,
  dec_issue_if.router                                    dec,
  output logic                                           f_rdy,
  input  logic [`DI_NUM_PIPES-1:0]                       x_rdy,
  output logic [`DI_NUM_PIPES-1:0]                       x_val,
  output logic [`DI_NUM_PIPES-1:0][31:0]                 x_pc,
  output logic [`DI_NUM_PIPES-1:0][31:0]                 x_op1,
  output logic [`DI_NUM_PIPES-1:0][31:0]                 x_op2,
  output logic [`DI_NUM_PIPES-1:0][31:0]                 x_imm,
  output logic [`DI_NUM_PIPES-1:0][4:0]                  x_waddr,
  output rv_uarch_pkg::rv_uop [`DI_NUM_PIPES-1:0]        x_uop,
  output logic [`DI_NUM_PIPES-1:0][`DI_SEQ_NUM_BITS-1:0] x_seq_num
);
  import rv_uarch_pkg::*;

  seq_num_t                 next_seq;
  logic                     out_of_rst;
  logic                     hazard;
  logic [`DI_NUM_PIPES-1:0] pipe_free;
  logic [`DI_NUM_PIPES-1:0] load;
  logic [31:0]              op1;
  logic [31:0]              op2;

  assign hazard = (dec.bundle.uses_rs1 && dec.rs1_busy) ||
                  (dec.bundle.uses_rs2 && dec.rs2_busy);

  // Empty, or handing its item to the pipe this cycle
  assign pipe_free = ~x_val | x_rdy;

  assign f_rdy      = out_of_rst && !hazard && pipe_free[dec.bundle.pipe];
  assign dec.accept = dec.valid && f_rdy;

  always_comb begin
    for (int p = 0; p < `DI_NUM_PIPES; p++) begin
      load[p] = dec.accept && (dec.bundle.pipe == p);
    end
  end

  assign dec.claim       = dec.accept && (dec.bundle.waddr != '0);
  assign dec.claim_waddr = dec.bundle.waddr;
  assign dec.claim_seq   = next_seq;

  // Operand select, jal takes pc and zero
  assign op1 = dec.bundle.uses_rs1 ? dec.rs1_data : dec.bundle.pc;
  assign op2 = dec.bundle.op2_is_imm ? dec.bundle.imm :
               (dec.bundle.uses_rs2 ? dec.rs2_data : '0);

  //----------------------------------------------------------
  // Control state
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      out_of_rst <= 1'b0;
      next_seq   <= '0;
      x_val      <= '0;
    end else begin
      out_of_rst <= 1'b1;
      if (dec.accept) begin
        next_seq <= next_seq + 1'b1;
      end
      for (int p = 0; p < `DI_NUM_PIPES; p++) begin
        if (load[p]) begin
          x_val[p] <= 1'b1;
        end else if (x_rdy[p]) begin
          x_val[p] <= 1'b0;
        end
      end
    end
  end

  // Issue register payload
  always_ff @(posedge clk) begin
    for (int p = 0; p < `DI_NUM_PIPES; p++) begin
      if (load[p]) begin
        x_pc[p]      <= dec.bundle.pc;
        x_op1[p]     <= op1;
        x_op2[p]     <= op2;
        x_imm[p]     <= dec.bundle.imm;
        x_waddr[p]   <= dec.bundle.waddr;
        x_uop[p]     <= dec.bundle.uop;
        x_seq_num[p] <= next_seq;
      end
    end
  end

  //----------------------------------------------------------
  // Checks
  //----------------------------------------------------------

  for (genvar gp = 0; gp < `DI_NUM_PIPES; gp++) begin : g_hold
    a_hold_stalled: assert property (
      @(posedge clk) disable iff (rst)
      (x_val[gp] && !x_rdy[gp]) |=>
        (x_val[gp] && $stable({x_pc[gp], x_op1[gp], x_op2[gp], x_imm[gp],
                               x_waddr[gp], x_uop[gp], x_seq_num[gp]}))
    ) else $error("issue_router: pipe %0d changed while stalled", gp);
  end

  // New items appear on one pipe at a time, one cycle after an accept
  a_single_load: assert property (
    @(posedge clk) disable iff (rst)
    (|(x_val & ~$past(x_val))) |-> ($onehot0(x_val & ~$past(x_val)) && $past(dec.accept))
  ) else $error("issue_router: more than one pipe loaded");

endmodule

`default_nettype wire

//--- hdl/decode_issue_unit.sv
//------------------------------------------------------------
// Decode and issue stage top level
// Decoder, scoreboard and router behind plain ports
//------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "decode_issue_cfg.svh"

module decode_issue_unit (
  input  logic                                           clk,
  input  logic                                           rst,

  // Fetch stream
  input  logic                                           f_val,
  output logic                                           f_rdy,
  input  logic [31:0]                                    f_pc,
  input  logic [31:0]                                    f_inst,

  // Execute pipes, index is the pipe class
  output logic [`DI_NUM_PIPES-1:0]                       x_val,
  input  logic [`DI_NUM_PIPES-1:0]                       x_rdy,
  output logic [`DI_NUM_PIPES-1:0][31:0]                 x_pc,
  output logic [`DI_NUM_PIPES-1:0][31:0]                 x_op1,
  output logic [`DI_NUM_PIPES-1:0][31:0]                 x_op2,
  output logic [`DI_NUM_PIPES-1:0][31:0]                 x_imm,
  output logic [`DI_NUM_PIPES-1:0][4:0]                  x_waddr,
  output rv_uarch_pkg::rv_uop [`DI_NUM_PIPES-1:0]        x_uop,
  output logic [`DI_NUM_PIPES-1:0][`DI_SEQ_NUM_BITS-1:0] x_seq_num,

  // Completion publish
  input  logic                                           c_val,
  input  logic [`DI_SEQ_NUM_BITS-1:0]                    c_seq_num,
  input  logic [4:0]                                     c_waddr,
  input  logic [31:0]                                    c_wdata,
  input  logic                                           c_wen
);

  dec_issue_if dec_if (.clk(clk));
  complete_if  comp_if ();

  assign comp_if.val     = c_val;
  assign comp_if.seq_num = c_seq_num;
  assign comp_if.waddr   = c_waddr;
  assign comp_if.wdata   = c_wdata;
  assign comp_if.wen     = c_wen;

  instr_decoder decoder_inst (
    .inst  (f_inst),
    .pc    (f_pc),
    .f_val (f_val),
    .dec   (dec_if.decoder)
  );

  reg_scoreboard scoreboard_inst (
    .clk  (clk),
    .rst  (rst),
    .dec  (dec_if.scoreboard),
    .comp (comp_if.sink)
  );

  issue_router router_inst (
    .clk       (clk),
    .rst       (rst),
    .dec       (dec_if.router),
    .f_rdy     (f_rdy),
    .x_rdy     (x_rdy),
    .x_val     (x_val),
    .x_pc      (x_pc),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_imm     (x_imm),
    .x_waddr   (x_waddr),
    .x_uop     (x_uop),
    .x_seq_num (x_seq_num)
  );

endmodule

`default_nettype wire

//--- bench/decode_issue_tb.sv
//------------------------------------------------------------
// Testbench for the decode and issue stage
// Random TinyRV1 stream, execute pipe and completion models
//------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "decode_issue_cfg.svh"

module decode_issue_tb;
  import rv_uarch_pkg::*;

  localparam int          NUM_RANDOM = 300;
  localparam int          NUM_BURST  = 4;
  localparam int          NUM_TOTAL  = NUM_RANDOM + NUM_BURST;
  localparam int          MAX_CYCLES = 20 * NUM_TOTAL + 200;
  localparam int          SEQ_SPAN   = 1 << `DI_SEQ_NUM_BITS;
  localparam logic [31:0] PC_BASE    = 32'h0000_1000;

  // Expected issue on one pipe
  typedef struct packed {
    logic        burst;
    logic [3:0]  delay;
    logic [1:0]  pipe;
    logic [15:0] idx;
    rv_uop       uop;
    logic [4:0]  waddr;
    logic [31:0] pc;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] imm;
    logic [31:0] result;
  } want_t;

  // Completion waiting to be published
  typedef struct packed {
    logic [31:0] due;
    logic [15:0] idx;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } comp_t;

  logic                                           clk;
  logic                                           rst;
  logic                                           f_val;
  logic                                           f_rdy;
  logic [31:0]                                    f_pc;
  logic [31:0]                                    f_inst;
  logic [`DI_NUM_PIPES-1:0]                       x_val;
  logic [`DI_NUM_PIPES-1:0]                       x_rdy;
  logic [`DI_NUM_PIPES-1:0][31:0]                 x_pc;
  logic [`DI_NUM_PIPES-1:0][31:0]                 x_op1;
  logic [`DI_NUM_PIPES-1:0][31:0]                 x_op2;
  logic [`DI_NUM_PIPES-1:0][31:0]                 x_imm;
  logic [`DI_NUM_PIPES-1:0][4:0]                  x_waddr;
  rv_uop [`DI_NUM_PIPES-1:0]                      x_uop;
  logic [`DI_NUM_PIPES-1:0][`DI_SEQ_NUM_BITS-1:0] x_seq_num;
  logic                                           c_val;
  logic [`DI_SEQ_NUM_BITS-1:0]                    c_seq_num;
  logic [4:0]                                     c_waddr;
  logic [31:0]                                    c_wdata;
  logic                                           c_wen;

  integer       seed;
  want_t        pipe_q [`DI_NUM_PIPES][$];
  comp_t        comp_q [$];
  logic [31:0]  arch [32];
  bit           is_writer [NUM_TOTAL];
  bit           wdone [NUM_TOTAL];
  logic [140:0] held [`DI_NUM_PIPES];
  bit           held_val [`DI_NUM_PIPES];
  int           gen_count;
  int           acc_count;
  int           oldest;
  int           cycle;
  int           checks [1:6];
  int           errs [1:6];
  string        test_name [1:6];
  int           total_checks;
  int           total_errs;
  bit           timed_out;
  bit           finished;
  bit           accepted;

  decode_issue_unit decode_issue_unit_inst (
    .clk       (clk),
    .rst       (rst),
    .f_val     (f_val),
    .f_rdy     (f_rdy),
    .f_pc      (f_pc),
    .f_inst    (f_inst),
    .x_val     (x_val),
    .x_rdy     (x_rdy),
    .x_pc      (x_pc),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_imm     (x_imm),
    .x_waddr   (x_waddr),
    .x_uop     (x_uop),
    .x_seq_num (x_seq_num),
    .c_val     (c_val),
    .c_seq_num (c_seq_num),
    .c_waddr   (c_waddr),
    .c_wdata   (c_wdata),
    .c_wen     (c_wen)
  );

  always #4 clk = ~clk;

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic bit drained();
    bit empty;
    empty = (comp_q.size() == 0) && (acc_count == gen_count);
    for (int p = 0; p < `DI_NUM_PIPES; p++) begin
      if (pipe_q[p].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  function automatic logic [140:0] pipe_fields(input int p);
    return {x_pc[p], x_op1[p], x_op2[p], x_imm[p], x_waddr[p], x_uop[p], x_seq_num[p]};
  endfunction

  task automatic check_val(input int test, input string name,
                           input logic [31:0] got, input logic [31:0] want);
    checks[test]++;
    assert (got === want) else begin
      $display("** Error %s: got %h, expected %h", name, got, want);
      errs[test]++;
    end
  endtask

  //----------------------------------------------------------
  // Instruction model
  //----------------------------------------------------------

  // Kind numbering follows the uop order
  task automatic add_instr(input int kind, input int rd, input int rs1, input int rs2,
                           input logic [31:0] r, input int delay, input bit burst);
    want_t       e;
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] word;
    logic [2:0]  f3;
    logic [6:0]  opc;
    d  = rd[4:0];
    s1 = rs1[4:0];
    s2 = rs2[4:0];
    a  = arch[s1];
    b  = arch[s2];
    pc = PC_BASE + 32'(gen_count) * 4;
    e  = '0;
    e.uop = rv_uop'(kind[2:0]);
    case (kind)
      0, 2: begin
        word     = {(kind == 2) ? 7'b0000001 : 7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
        e.pipe   = (kind == 2) ? 2'd1 : 2'd0;
        e.op1    = a;
        e.op2    = b;
        e.result = (kind == 2) ? a * b : a + b;
        e.waddr  = d;
      end
      1, 3, 6: begin
        // addi, lw and jalr share the I format
        imm      = {{20{r[11]}}, r[11:0]};
        f3       = (kind == 3) ? 3'b010 : 3'b000;
        opc      = (kind == 1) ? 7'b0010011 : ((kind == 3) ? 7'b0000011 : 7'b1100111);
        word     = {imm[11:0], s1, f3, d, opc};
        e.pipe   = (kind == 3) ? 2'd2 : 2'd0;
        e.op1    = a;
        e.op2    = imm;
        e.imm    = imm;
        e.result = (kind == 1) ? a + imm : ((kind == 3) ? (a + imm) ^ 32'h5a5a_5a5a : pc + 4);
        e.waddr  = d;
      end
      4: begin
        imm    = {{20{r[11]}}, r[11:0]};
        word   = {imm[11:5], s2, s1, 3'b010, imm[4:0], 7'b0100011};
        e.pipe = 2'd2;
        e.op1  = a;
        e.op2  = b;
        e.imm  = imm;
      end
      5: begin
        imm      = {{11{r[20]}}, r[20:1], 1'b0};
        word     = {imm[20], imm[10:1], imm[11], imm[19:12], d, 7'b1101111};
        e.op1    = pc;
        e.imm    = imm;
        e.result = pc + 4;
        e.waddr  = d;
      end
      default: begin
        imm   = {{19{r[12]}}, r[12:1], 1'b0};
        word  = {imm[12], imm[10:5], s2, s1, 3'b001, imm[4:1], imm[11], 7'b1100011};
        e.op1 = a;
        e.op2 = b;
        e.imm = imm;
      end
    endcase
    e.pc    = pc;
    e.idx   = gen_count[15:0];
    e.delay = delay[3:0];
    e.burst = burst;
    // Program order update of the register model
    if (e.waddr != 0) begin
      arch[e.waddr] = e.result;
    end
    is_writer[gen_count] = (e.waddr != 0);
    pipe_q[e.pipe].push_back(e);
    f_val  <= 1'b1;
    f_pc   <= pc;
    f_inst <= word;
    gen_count++;
  endtask

  // Two writes to x5 where the older one completes first
  task automatic gen_burst(input int step);
    case (step)
      0:       add_instr(2, 5, 1, 2, 32'h0, 1, 1'b1);
      1:       add_instr(1, 5, 3, 0, 32'h123, 8, 1'b1);
      2:       add_instr(0, 6, 5, 5, 32'h0, 0, 1'b1);
      default: add_instr(4, 0, 5, 6, 32'h10, 0, 1'b1);
    endcase
  endtask

  task automatic present_next();
    bit          room;
    bit          go;
    int          kind;
    int          rd;
    int          rs1;
    int          rs2;
    logic [31:0] r;
    room = (gen_count - oldest) < SEQ_SPAN - 1;
    if (gen_count < NUM_RANDOM) begin
      go = room && (rand_below(4) != 0);
    end else begin
      go = (gen_count < NUM_TOTAL) && room && (gen_count > NUM_RANDOM || drained());
    end
    if (!go) begin
      f_val <= 1'b0;
    end else if (gen_count < NUM_RANDOM) begin
      kind = rand_below(8);
      rd   = rand_below(8);
      rs1  = rand_below(8);
      rs2  = rand_below(8);
      r    = $random(seed);
      add_instr(kind, rd, rs1, rs2, r, 0, 1'b0);
    end else begin
      gen_burst(gen_count - NUM_RANDOM);
    end
  endtask

  //----------------------------------------------------------
  // Execute pipe and completion models
  //----------------------------------------------------------

  task automatic take_transfer(input int p);
    want_t e;
    comp_t c;
    int    t;
    checks[2]++;
    assert (pipe_q[p].size() != 0) else begin
      $display("Transfer on pipe %0d while no instruction was expected there", p);
      errs[2]++;
    end
    if (pipe_q[p].size() != 0) begin
      e = pipe_q[p].pop_front();
      t = e.burst ? 6 : 3;
      check_val(2, $sformatf("x_uop[%0d]", p), x_uop[p], e.uop);
      check_val(2, $sformatf("x_pc[%0d]", p), x_pc[p], e.pc);
      check_val(2, $sformatf("x_waddr[%0d]", p), x_waddr[p], e.waddr);
      check_val(2, $sformatf("x_imm[%0d]", p), x_imm[p], e.imm);
      check_val(t, $sformatf("x_op1[%0d]", p), x_op1[p], e.op1);
      check_val(t, $sformatf("x_op2[%0d]", p), x_op2[p], e.op2);
      check_val(4, $sformatf("x_seq_num[%0d]", p), x_seq_num[p], 32'(e.idx) % SEQ_SPAN);
      if (e.waddr != 0) begin
        c.due   = cycle + ((e.delay != 0) ? int'(e.delay) : 1 + rand_below(4));
        c.idx   = e.idx;
        c.waddr = e.waddr;
        c.wdata = e.result;
        comp_q.push_back(c);
      end
    end
  endtask

  task automatic observe_pipe(input int p);
    logic [140:0] now_fields;
    now_fields = pipe_fields(p);
    if (held_val[p]) begin
      check_val(5, $sformatf("x_val[%0d]", p), x_val[p], 1);
      checks[5]++;
      assert (now_fields === held[p]) else begin
        $display("** Error x_*[%0d] fields: got %h, expected %h", p, now_fields, held[p]);
        errs[5]++;
      end
    end
    held_val[p] = x_val[p] && !x_rdy[p];
    held[p]     = now_fields;
    if (x_val[p] && x_rdy[p]) begin
      take_transfer(p);
    end
  endtask

  // First due entry goes out, so completions may pass each other
  task automatic publish_completion();
    int pick;
    pick = -1;
    for (int i = 0; i < comp_q.size(); i++) begin
      if (pick < 0 && comp_q[i].due <= cycle) begin
        pick = i;
      end
    end
    if (pick >= 0) begin
      c_val     <= 1'b1;
      c_wen     <= 1'b1;
      c_seq_num <= comp_q[pick].idx[`DI_SEQ_NUM_BITS-1:0];
      c_waddr   <= comp_q[pick].waddr;
      c_wdata   <= comp_q[pick].wdata;
      wdone[comp_q[pick].idx] = 1'b1;
      comp_q.delete(pick);
    end else begin
      c_val <= 1'b0;
      c_wen <= 1'b0;
    end
  endtask

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------

  initial begin
    seed      = 32'h66a1_ef8b;
    clk       = 1'b0;
    rst       = 1'b1;
    f_val     = 1'b0;
    f_pc      = '0;
    f_inst    = '0;
    x_rdy     = '0;
    c_val     = 1'b0;
    c_seq_num = '0;
    c_waddr   = '0;
    c_wdata   = '0;
    c_wen     = 1'b0;
    gen_count = 0;
    acc_count = 0;
    oldest    = 0;
    cycle     = 0;
    timed_out = 1'b0;
    finished  = 1'b0;
    for (int i = 0; i < 32; i++) begin
      arch[i] = '0;
    end
    for (int i = 0; i < NUM_TOTAL; i++) begin
      is_writer[i] = 1'b0;
      wdone[i]     = 1'b0;
    end
    for (int t = 1; t <= 6; t++) begin
      checks[t] = 0;
      errs[t]   = 0;
    end
    for (int p = 0; p < `DI_NUM_PIPES; p++) begin
      held_val[p] = 1'b0;
      held[p]     = '0;
    end
    test_name[1] = "after reset";
    test_name[2] = "routing";
    test_name[3] = "operands under hazards";
    test_name[4] = "sequence numbers";
    test_name[5] = "back-pressure hold";
    test_name[6] = "WAW ordering";

    // Outputs are unknown before the first reset edge
    for (int k = 0; k < 5; k++) begin
      @(posedge clk);
      if (k > 0) begin
        check_val(1, "x_val", x_val, 0);
        check_val(1, "f_rdy", f_rdy, 0);
      end
    end
    rst <= 1'b0;
    $display("Test 1 %s: %0d checks, %0d errors", test_name[1], checks[1], errs[1]);

    while (!finished && !timed_out) begin
      @(posedge clk);
      cycle++;
      for (int p = 0; p < `DI_NUM_PIPES; p++) begin
        observe_pipe(p);
      end
      accepted = f_val && f_rdy;
      if (accepted) begin
        acc_count++;
      end
      publish_completion();
      while (oldest < gen_count && (!is_writer[oldest] || wdone[oldest])) begin
        oldest++;
      end
      for (int p = 0; p < `DI_NUM_PIPES; p++) begin
        x_rdy[p] <= (rand_below(10) < 7);
      end
      if (!f_val || accepted) begin
        present_next();
      end
      finished = (acc_count == NUM_TOTAL) && drained();
      if (!finished && cycle >= MAX_CYCLES) begin
        timed_out = 1'b1;
        $display("Timeout: %0d of %0d instructions accepted after %0d cycles",
                 acc_count, NUM_TOTAL, cycle);
      end
    end

    total_checks = 0;
    total_errs   = 0;
    for (int t = 2; t <= 6; t++) begin
      $display("Test %0d %s: %0d checks, %0d errors", t, test_name[t], checks[t], errs[t]);
    end
    for (int t = 1; t <= 6; t++) begin
      total_checks += checks[t];
      total_errs   += errs[t];
    end
    $display("Totals: %0d checks, %0d errors", total_checks, total_errs);
    if (timed_out || total_errs != 0) begin
      $display("Something failed");
    end else begin
      $display("Everything OK");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hdl/rv_uarch_pkg.sv
hdl/decode_issue_ifs.sv
hdl/instr_decoder.sv
hdl/reg_scoreboard.sv
hdl/issue_router.sv
hdl/decode_issue_unit.sv
bench/decode_issue_tb.sv

//--- Bender.yml
package:
  name: decode_issue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/rv_uarch_pkg.sv
      - hdl/decode_issue_ifs.sv
      - hdl/instr_decoder.sv
      - hdl/reg_scoreboard.sv
      - hdl/issue_router.sv
      - hdl/decode_issue_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/decode_issue_tb.sv
